// File: Bender.yml
package:
  name: axis_pkt_gen

sources:
  - files:
      - source/pkt_gen_pkg.sv
      - source/sync_pipe.sv
      - source/link_sequencer.sv
      - source/frame_builder.sv
      - source/axis_pkt_gen.sv
  - target: test
    files:
      - testbench/pkt_gen_props.sv
      - testbench/pkt_gen_checker.sv
      - testbench/tb_axis_pkt_gen.sv

// File: sim.f
source/pkt_gen_pkg.sv
source/sync_pipe.sv
source/link_sequencer.sv
source/frame_builder.sv
source/axis_pkt_gen.sv
testbench/pkt_gen_props.sv
testbench/pkt_gen_checker.sv
testbench/tb_axis_pkt_gen.sv

// File: source/axis_pkt_gen.sv
module axis_pkt_gen
    import pkt_gen_pkg::*;
#(
    parameter int PKT_NUM  = 4,
    parameter int PKT_SIZE = 150
) (
    input  logic       clk,
    input  logic       sys_reset,
    input  logic       rx_aligned,
    input  logic       restart,
    input  logic       continuous,
    input  logic       tx_ovf,
    input  logic       tx_unf,
    input  beat_data_t src_data,
    input  logic       src_valid,
    output logic       src_ready,
    output beat_data_t tx_axis_tdata,
    output keep_t      tx_axis_tkeep,
    output logic       tx_axis_tlast,
    output logic       tx_axis_tvalid,
    input  logic       tx_axis_tready,
    output logic       ctl_tx_enable,
    output logic       ctl_tx_send_rfi,
    output logic       tx_gt_locked_led,
    output logic       tx_busy_led,
    output logic       tx_done_led,
    output logic       run_failed
);

    logic rx_aligned_s;
    logic restart_s;
    logic continuous_s;
    logic run_start;
    logic run_enable;
    logic run_last;
    logic locked;
    logic busy;
    logic done;

    // rx_aligned, restart, continuous
    sync_pipe #(
        .payload_t (logic [2:0]),
        .STAGES    (SYNC_STAGES)
    ) in_sync (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         ({rx_aligned, restart, continuous}),
        .q         ({rx_aligned_s, restart_s, continuous_s})
    );

    link_sequencer link_sequencer (
        .clk             (clk),
        .sys_reset       (sys_reset),
        .rx_aligned      (rx_aligned_s),
        .restart         (restart_s),
        .tx_ready        (tx_axis_tready),
        .tx_ovf          (tx_ovf),
        .tx_unf          (tx_unf),
        .run_last        (run_last),
        .run_start       (run_start),
        .run_enable      (run_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_rfi (ctl_tx_send_rfi),
        .locked          (locked),
        .busy            (busy),
        .done            (done),
        .run_failed      (run_failed)
    );

    frame_builder #(
        .PKT_NUM  (PKT_NUM),
        .PKT_SIZE (PKT_SIZE)
    ) frame_builder (
        .clk            (clk),
        .sys_reset      (sys_reset),
        .run_start      (run_start),
        .run_enable     (run_enable),
        .continuous     (continuous_s),
        .src_data       (src_data),
        .src_valid      (src_valid),
        .src_ready      (src_ready),
        .tx_axis_tdata  (tx_axis_tdata),
        .tx_axis_tkeep  (tx_axis_tkeep),
        .tx_axis_tlast  (tx_axis_tlast),
        .tx_axis_tvalid (tx_axis_tvalid),
        .tx_axis_tready (tx_axis_tready),
        .run_last       (run_last)
    );

    // status LEDs
    sync_pipe #(
        .payload_t (logic [2:0]),
        .STAGES    (LED_STAGES)
    ) led_pipe (
        .clk       (clk),
        .sys_reset (sys_reset),
        .d         ({locked, busy, done}),
        .q         ({tx_gt_locked_led, tx_busy_led, tx_done_led})
    );

endmodule

// File: source/frame_builder.sv
module frame_builder
    import pkt_gen_pkg::*;
#(
    parameter int PKT_NUM  = 4,
    parameter int PKT_SIZE = 150
) (
    input  logic       clk,
    input  logic       sys_reset,
    input  logic       run_start,
    input  logic       run_enable,
    input  logic       continuous,
    input  beat_data_t src_data,
    input  logic       src_valid,
    output logic       src_ready,
    output beat_data_t tx_axis_tdata,
    output keep_t      tx_axis_tkeep,
    output logic       tx_axis_tlast,
    output logic       tx_axis_tvalid,
    input  logic       tx_axis_tready,
    output logic       run_last
);

    localparam byte_count_t SIZE_BYTES = byte_count_t'(PKT_SIZE);
    localparam pkt_count_t  LAST_PKT   = pkt_count_t'(PKT_NUM - 1);
    localparam keep_t       TAIL_KEEP  = last_keep_mask(SIZE_BYTES);

    byte_count_t bytes_left;
    pkt_count_t  pkt_cnt;
    logic        run_loaded;
    logic        final_q;
    logic        enable_q;
    logic        take;
    logic        beat_last;
    logic        beat_final;
    logic        flush;

    ////////////////////////////////////////////////////////////////////////////
    // source pull
    ////////////////////////////////////////////////////////////////////////////
    assign src_ready = run_enable && !run_start && !run_loaded
                       && (!tx_axis_tvalid || tx_axis_tready);
    assign take       = src_ready && src_valid;
    assign beat_last  = bytes_left <= byte_count_t'(DATA_BYTES);
    assign beat_final = beat_last && !continuous && (pkt_cnt >= LAST_PKT);

    // a single low cycle is a halt, two in a row end the run
    assign flush = !run_enable && !enable_q;

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            bytes_left <= '0;
            pkt_cnt    <= '0;
            run_loaded <= 1'b0;
            enable_q   <= 1'b0;
        end
        else
        begin
            enable_q <= run_enable;
            if (run_start)
            begin
                bytes_left <= SIZE_BYTES;
                pkt_cnt    <= '0;
                run_loaded <= 1'b0;
            end
            else if (take)
            begin
                if (beat_last)
                begin
                    bytes_left <= SIZE_BYTES;
                    // saturate for long continuous runs
                    if (pkt_cnt != '1)
                        pkt_cnt <= pkt_cnt + 1'b1;
                    run_loaded <= beat_final;
                end
                else
                begin
                    bytes_left <= bytes_left - byte_count_t'(DATA_BYTES);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            tx_axis_tvalid <= 1'b0;
            final_q        <= 1'b0;
        end
        else if (take)
        begin
            tx_axis_tvalid <= 1'b1;
            final_q        <= beat_final;
        end
        else if ((tx_axis_tvalid && tx_axis_tready) || flush)
        begin
            tx_axis_tvalid <= 1'b0;
            final_q        <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            tx_axis_tdata <= src_data;
            tx_axis_tkeep <= beat_last ? TAIL_KEEP : '1;
            tx_axis_tlast <= beat_last;
        end
    end

    assign run_last = tx_axis_tvalid && tx_axis_tready && final_q;

endmodule

// File: source/link_sequencer.sv
module link_sequencer
    import pkt_gen_pkg::*;
(
    input  logic clk,
    input  logic sys_reset,
    input  logic rx_aligned,
    input  logic restart,
    input  logic tx_ready,
    input  logic tx_ovf,
    input  logic tx_unf,
    input  logic run_last,
    output logic run_start,
    output logic run_enable,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_rfi,
    output logic locked,
    output logic busy,
    output logic done,
    output logic run_failed
);

    tx_state_t state;
    tx_state_t state_next;

    logic                ready_q;
    logic                ovf_q;
    logic                unf_q;
    logic                fault;
    logic                restart_q;
    logic                restart_rise;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                settle_ok;
    logic                link_watch;

    ////////////////////////////////////////////////////////////////////////////
    // MAC status and restart edge
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            ready_q      <= 1'b0;
            ovf_q        <= 1'b0;
            unf_q        <= 1'b0;
            restart_q    <= 1'b0;
            restart_rise <= 1'b0;
        end
        else
        begin
            ready_q      <= tx_ready;
            ovf_q        <= tx_ovf;
            unf_q        <= tx_unf;
            restart_q    <= restart;
            restart_rise <= restart && !restart_q;
        end
    end

    assign fault = ovf_q || unf_q;

    // counts up to INIT_WAIT - 1, then holds
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
            settle_cnt <= '0;
        else if (state != settle)
            settle_cnt <= '0;
        else if (!settle_ok)
            settle_cnt <= settle_cnt + 1'b1;
    end

    assign settle_ok = settle_cnt == SETTLE_W'(INIT_WAIT - 1);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////
    assign link_watch = state inside {settle, transfer, halt, pkt_gen_pkg::done, wait_restart};

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
                state_next = send_rfi;
            send_rfi:
                state_next = wait_aligned;
            wait_aligned:
                if (rx_aligned)
                    state_next = settle;
            settle:
                if (settle_ok && ready_q && !fault)
                    state_next = transfer;
            transfer:
                if (run_last)
                    state_next = pkt_gen_pkg::done;
                else if (fault)
                    state_next = halt;
            // fault still present after one cycle aborts the run
            halt:
                if (run_last || fault)
                    state_next = pkt_gen_pkg::done;
                else
                    state_next = transfer;
            pkt_gen_pkg::done:
                state_next = wait_restart;
            wait_restart:
                if (restart_rise)
                    state_next = settle;
            default:
                state_next = idle;
        endcase

        // alignment lost
        if (link_watch && !rx_aligned)
            state_next = idle;
    end

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            state     <= idle;
            run_start <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            run_start <= (state == settle) && (state_next == transfer);
        end
    end

    // sticky result flags
    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            done       <= 1'b0;
            run_failed <= 1'b0;
        end
        else if (state == wait_restart && restart_rise)
        begin
            done       <= 1'b0;
            run_failed <= 1'b0;
        end
        else
        begin
            if (state == pkt_gen_pkg::done)
                done <= 1'b1;
            if (state == halt && fault && !run_last)
                run_failed <= 1'b1;
        end
    end

    assign run_enable      = state == transfer;
    assign ctl_tx_enable   = link_watch;
    assign ctl_tx_send_rfi = state inside {send_rfi, wait_aligned};
    assign locked          = state != idle;
    assign busy            = state inside {settle, transfer, halt};

endmodule

// File: source/pkt_gen_pkg.sv
package pkt_gen_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stream geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int DATA_BYTES = 64;
    localparam int DATA_W     = DATA_BYTES * 8;
    localparam int BEAT_IDX_W = $clog2(DATA_BYTES);
    localparam int SIZE_W     = 14;
    localparam int COUNT_W    = 16;

    // timing
    localparam int SYNC_STAGES = 3;
    localparam int LED_STAGES  = 3;
    localparam int INIT_WAIT   = 16;
    localparam int SETTLE_W    = $clog2(INIT_WAIT);

    typedef logic [DATA_W-1:0]     beat_data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;
    typedef logic [SIZE_W-1:0]     byte_count_t;
    typedef logic [COUNT_W-1:0]    pkt_count_t;

    typedef enum logic [2:0] {
        idle,
        send_rfi,
        wait_aligned,
        settle,
        transfer,
        halt,
        done,
        wait_restart
    } tx_state_t;

    // bytes of the closing beat, low bytes first
    function automatic keep_t last_keep_mask(input byte_count_t size);
        logic [BEAT_IDX_W-1:0] tail;
        tail = size[BEAT_IDX_W-1:0];
        if (tail == '0)
            return '1;
        else
            return ~({DATA_BYTES{1'b1}} << tail);
    endfunction

endpackage

// File: source/sync_pipe.sv
module sync_pipe #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 2
) (
    input  logic     clk,
    input  logic     sys_reset,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q [STAGES];

    always_ff @(posedge clk or posedge sys_reset)
    begin
        if (sys_reset)
        begin
            for (int i = 0; i < STAGES; i++)
                stage_q[i] <= '0;
        end
        else
        begin
            stage_q[0] <= d;
            for (int i = 1; i < STAGES; i++)
                stage_q[i] <= stage_q[i-1];
        end
    end

    assign q = stage_q[STAGES-1];

endmodule

// File: testbench/pkt_gen_checker.sv
module pkt_gen_checker
    import pkt_gen_pkg::*;
#(
    parameter int PKT_SIZE = 150
) (
    input logic       clk,
    input logic       sys_reset,
    input beat_data_t src_data,
    input logic       src_valid,
    input logic       src_ready,
    input beat_data_t tx_axis_tdata,
    input keep_t      tx_axis_tkeep,
    input logic       tx_axis_tlast,
    input logic       tx_axis_tvalid,
    input logic       tx_axis_tready,
    input logic       tx_busy_led
);
    timeunit 1ns;
    timeprecision 1ps;

    string      test_name = "reset";
    int         errors = 0;
    int         beat_count = 0;
    int         pkt_count = 0;
    int         beat_idx = 0;
    logic       busy_q = 1'b0;
    beat_data_t exp_q [$];

    // {last, keep} for a beat position inside a packet
    function automatic logic [DATA_BYTES:0] expected_beat(input int idx);
        int    beats;
        int    tail;
        keep_t keep;
        beats = (PKT_SIZE + DATA_BYTES - 1) / DATA_BYTES;
        tail  = PKT_SIZE - (beats - 1) * DATA_BYTES;
        if (idx == beats - 1)
        begin
            // bytes the closing beat still carries
            for (int b = 0; b < DATA_BYTES; b++)
                keep[b] = (b < tail);
            return {1'b1, keep};
        end
        else
            return {1'b0, {DATA_BYTES{1'b1}}};
    endfunction

    task automatic expect_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %0b, actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic expect_int(input string what, input int exp, input int act);
        if (act != exp)
        begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        if (!cond)
        begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stream comparison
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        logic [DATA_BYTES:0] exp_kl;
        beat_data_t          exp_data;
        if (sys_reset)
        begin
            exp_q.delete();
            beat_idx <= 0;
            busy_q = 1'b0;
        end
        else
        begin
            // words left over from an aborted run are dropped at a new run
            if (tx_busy_led && !busy_q)
            begin
                exp_q.delete();
                beat_idx <= 0;
            end
            busy_q = tx_busy_led;
            if (tx_axis_tvalid && tx_axis_tready)
            begin
                exp_kl = expected_beat(beat_idx);
                beat_count <= beat_count + 1;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("%s: beat transferred with no source word behind it", test_name);
                end
                else
                begin
                    exp_data = exp_q.pop_front();
                    if (tx_axis_tdata !== exp_data)
                    begin
                        errors++;
                        $display("error %s tdata: expected %h, actual %h",
                                 test_name, exp_data, tx_axis_tdata);
                    end
                end
                if (tx_axis_tkeep !== exp_kl[DATA_BYTES-1:0])
                begin
                    errors++;
                    $display("error %s tkeep: expected %h, actual %h",
                             test_name, exp_kl[DATA_BYTES-1:0], tx_axis_tkeep);
                end
                expect_bit("tlast", exp_kl[DATA_BYTES], tx_axis_tlast);
                if (exp_kl[DATA_BYTES])
                begin
                    beat_idx  <= 0;
                    pkt_count <= pkt_count + 1;
                end
                else
                begin
                    beat_idx <= beat_idx + 1;
                end
            end
            if (src_valid && src_ready)
                exp_q.push_back(src_data);
        end
    end

endmodule

// File: testbench/pkt_gen_props.sv
module pkt_gen_props
    import pkt_gen_pkg::*;
(
    input logic       clk,
    input logic       sys_reset,
    input beat_data_t tx_axis_tdata,
    input keep_t      tx_axis_tkeep,
    input logic       tx_axis_tlast,
    input logic       tx_axis_tvalid,
    input logic       tx_axis_tready,
    input logic       src_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a stalled beat must not change under the MAC
    hold_while_stalled: assert property (@(posedge clk) disable iff (sys_reset)
        tx_axis_tvalid && !tx_axis_tready |=>
            $stable(tx_axis_tdata) && $stable(tx_axis_tkeep) && $stable(tx_axis_tlast))
    else
    begin
        fail_count++;
        $error("output beat changed while stalled");
    end

    keep_not_empty: assert property (@(posedge clk) disable iff (sys_reset)
        tx_axis_tvalid |-> tx_axis_tkeep != '0)
    else
    begin
        fail_count++;
        $error("valid beat with empty keep mask");
    end

    no_pull_while_stalled: assert property (@(posedge clk) disable iff (sys_reset)
        !(src_ready && tx_axis_tvalid && !tx_axis_tready))
    else
    begin
        fail_count++;
        $error("source pulled while output stalled");
    end

endmodule

bind axis_pkt_gen pkt_gen_props props (
    .clk            (clk),
    .sys_reset      (sys_reset),
    .tx_axis_tdata  (tx_axis_tdata),
    .tx_axis_tkeep  (tx_axis_tkeep),
    .tx_axis_tlast  (tx_axis_tlast),
    .tx_axis_tvalid (tx_axis_tvalid),
    .tx_axis_tready (tx_axis_tready),
    .src_ready      (src_ready)
);

// File: testbench/tb_axis_pkt_gen.sv
module tb_axis_pkt_gen
    import pkt_gen_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PKT_NUM         = 4;
    localparam int PKT_SIZE        = 150;
    localparam int BEATS_PER_PKT   = (PKT_SIZE + DATA_BYTES - 1) / DATA_BYTES;
    // all runs together, continuous one included, stay under ten runs' worth
    localparam int EXP_BEATS       = BEATS_PER_PKT * PKT_NUM * 10;
    localparam int WATCHDOG_CYCLES = 200 * EXP_BEATS + 2000;

    logic       clk = 1'b0;
    logic       sys_reset = 1'b1;
    logic       rx_aligned = 1'b0;
    logic       restart = 1'b0;
    logic       continuous = 1'b0;
    logic       tx_ovf = 1'b0;
    logic       tx_unf = 1'b0;
    beat_data_t src_data = '0;
    logic       src_valid = 1'b0;
    logic       src_ready;
    beat_data_t tx_axis_tdata;
    keep_t      tx_axis_tkeep;
    logic       tx_axis_tlast;
    logic       tx_axis_tvalid;
    logic       tx_axis_tready = 1'b0;
    logic       ctl_tx_enable;
    logic       ctl_tx_send_rfi;
    logic       tx_gt_locked_led;
    logic       tx_busy_led;
    logic       tx_done_led;
    logic       run_failed;

    int   seed = 32'h4f4d_7104;
    logic bp_on = 1'b0;
    int   run_base = 0;
    int   stray_beats;
    int   total_errors;

    axis_pkt_gen #(
        .PKT_NUM  (PKT_NUM),
        .PKT_SIZE (PKT_SIZE)
    ) dut (
        .*
    );

    pkt_gen_checker #(
        .PKT_SIZE (PKT_SIZE)
    ) pkt_check (
        .*
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    function automatic beat_data_t random_word();
        beat_data_t w;
        for (int i = 0; i < DATA_W / 32; i++)
            w[i*32 +: 32] = $random(seed);
        return w;
    endfunction

    // MAC back-pressure and source model
    always @(posedge clk)
    begin
        tx_axis_tready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
        if (!src_valid || src_ready)
        begin
            src_valid <= ($random(seed) & 7) != 0;
            src_data  <= random_word();
        end
    end

    task automatic wait_done();
        while (!tx_done_led)
            @(posedge clk);
    endtask

    // returns early if the run ends first
    task automatic wait_packets(input int n);
        while (pkt_check.pkt_count - run_base < n && !tx_done_led)
            @(posedge clk);
    endtask

    task automatic start_next_run(input string name);
        pkt_check.test_name = name;
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        while (tx_done_led)
            @(posedge clk);
        run_base = pkt_check.pkt_count;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        repeat (5) @(posedge clk);
        pkt_check.expect_bit("tx_gt_locked_led", 1'b0, tx_gt_locked_led);
        pkt_check.expect_bit("tx_axis_tvalid", 1'b0, tx_axis_tvalid);
        pkt_check.expect_bit("src_ready", 1'b0, src_ready);
        sys_reset <= 1'b0;

        pkt_check.test_name = "bring-up";
        repeat (10) @(posedge clk);
        pkt_check.expect_bit("ctl_tx_send_rfi", 1'b1, ctl_tx_send_rfi);
        pkt_check.expect_bit("ctl_tx_enable", 1'b0, ctl_tx_enable);
        pkt_check.expect_bit("tx_gt_locked_led", 1'b1, tx_gt_locked_led);

        pkt_check.test_name = "basic";
        run_base = pkt_check.pkt_count;
        rx_aligned <= 1'b1;
        wait_done();
        pkt_check.expect_int("packets", PKT_NUM, pkt_check.pkt_count - run_base);
        pkt_check.expect_bit("run_failed", 1'b0, run_failed);
        pkt_check.expect_bit("tx_busy_led", 1'b0, tx_busy_led);

        bp_on <= 1'b1;
        start_next_run("restart with back-pressure");
        wait_done();
        pkt_check.expect_int("packets", PKT_NUM, pkt_check.pkt_count - run_base);

        continuous <= 1'b1;
        start_next_run("continuous");
        wait_packets(2 * PKT_NUM + 1);
        continuous <= 1'b0;
        wait_done();
        pkt_check.check_true(pkt_check.pkt_count - run_base > PKT_NUM,
                             "continuous run did not go past PKT_NUM packets");
        pkt_check.expect_int("beat position at end", 0, pkt_check.beat_idx);

        start_next_run("fault abort");
        wait_packets(1);
        pkt_check.expect_bit("tx_busy_led", 1'b1, tx_busy_led);
        tx_ovf <= 1'b1;
        repeat (10) @(posedge clk);
        tx_ovf <= 1'b0;
        wait_done();
        pkt_check.expect_bit("run_failed", 1'b1, run_failed);
        stray_beats = 0;
        repeat (20)
        begin
            @(posedge clk);
            if (tx_axis_tvalid)
                stray_beats++;
        end
        pkt_check.check_true(stray_beats == 0, "tvalid came back after the aborted run");

        start_next_run("underflow pulse");
        pkt_check.expect_bit("run_failed after restart", 1'b0, run_failed);
        wait_packets(1);
        tx_unf <= 1'b1;
        @(posedge clk);
        tx_unf <= 1'b0;
        wait_done();
        pkt_check.expect_bit("run_failed", 1'b0, run_failed);
        pkt_check.expect_int("packets", PKT_NUM, pkt_check.pkt_count - run_base);

        start_next_run("link loss");
        wait_packets(1);
        pkt_check.expect_bit("ctl_tx_enable while linked", 1'b1, ctl_tx_enable);
        pkt_check.expect_bit("ctl_tx_send_rfi while linked", 1'b0, ctl_tx_send_rfi);
        rx_aligned <= 1'b0;
        // three sync stages, idle, then two cycles to flush the output
        repeat (8) @(posedge clk);
        pkt_check.expect_bit("ctl_tx_enable", 1'b0, ctl_tx_enable);
        pkt_check.expect_bit("ctl_tx_send_rfi", 1'b1, ctl_tx_send_rfi);
        pkt_check.expect_bit("tx_axis_tvalid", 1'b0, tx_axis_tvalid);

        pkt_check.test_name = "recovery";
        run_base = pkt_check.pkt_count;
        rx_aligned <= 1'b1;
        wait_done();
        pkt_check.expect_int("packets", PKT_NUM, pkt_check.pkt_count - run_base);

        repeat (5) @(posedge clk);
        total_errors = pkt_check.errors + dut.props.fail_count;
        $display("checks: %0d errors, %0d assertion failures, %0d beats, %0d packets",
                 pkt_check.errors, dut.props.fail_count,
                 pkt_check.beat_count, pkt_check.pkt_count);
        if (total_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
